// ==== build.f ====
+incdir+rtl
rtl/xbar_pkg.sv
rtl/pkt_fifo.sv
rtl/fwd_cam.sv
rtl/out_arbiter.sv
rtl/xbar_top.sv
dv/xbar_tb.sv

// ==== dv/xbar_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Crossbar testbench: LFSR stimulus, reference router, beat checker
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

module xbar_tb import xbar_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_in  = `XBAR_NUM_INPUTS;
   localparam int n_out = `XBAR_NUM_OUTPUTS;
   localparam logic [7:0] local_net = 8'h5A;

   logic clk = 1'b0;
   logic reset;
   logic clear;
   axis_beat_t in_beat [n_in] = '{default: '0};
   logic [n_in-1:0] in_stb = '0;
   set_bus_t set_bus;
   logic [7:0] local_addr;
   logic [`XBAR_IN_W-1:0] rb_in;
   logic [`XBAR_PORT_W-1:0] rb_port;
   axis_beat_t out_beat [n_out];
   logic [n_out-1:0] out_stb;
   logic [31:0] rb_data;

   logic [15:0] lfsr = 16'd51;
   // Beats waiting to be driven, per input
   logic [64:0] tx_q [n_in][$];
   // Expected beats, indexed by output * n_in + input
   logic [64:0] exp_q [n_in*n_out][$];
   // Copy of each CAM table, with a flag for entries known to the testbench
   logic [1:0] tbl_mirror [n_in][`XBAR_CAM_SPAN];
   logic tbl_known [n_in][`XBAR_CAM_SPAN];
   int exp_stat [n_in][n_out];
   int sent_pkts [n_in];
   int done_pkts [n_in];
   logic [n_in-1:0] mid_tx = '0;
   logic [n_out-1:0] mid_rx = '0;
   int cur_src [n_out];
   int total_beats = 0;
   int cycles = 0;
   int check_errs = 0;
   int other_errs = 0;
   logic [15:0] seq = '0;

   always #10 clk = ~clk;

   xbar_top DUT (
      .clk          (clk),
      .i_reset      (reset),
      .i_clear      (clear),
      .i_in         (in_beat),
      .i_in_stb     (in_stb),
      .i_set        (set_bus),
      .i_local_addr (local_addr),
      .i_rb_in      (rb_in),
      .i_rb_port    (rb_port),
      .o_out        (out_beat),
      .o_out_stb    (out_stb),
      .o_rb_data    (rb_data)
   );

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[15]};
         lfsr = lfsr_next(lfsr);
      end
      return r;
   endfunction

   // Local network goes to the host bank, anything else to the network bank
   function automatic int route_index(input sid_t sid, input logic [7:0] net);
      if (sid.dst_net == net) begin
         return 256 + int'(sid.dst_host);
      end
      return int'(sid.dst_net);
   endfunction

   function automatic logic [1:0] route_port(input int k, input sid_t sid,
                                             input logic [7:0] net);
      return tbl_mirror[k][route_index(sid, net)];
   endfunction

   task automatic check_value(input logic [64:0] got, input logic [64:0] want,
                              input string what);
      if (got !== want) begin
         check_errs++;
         $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
      end
   endtask

   task automatic print_summary();
      $display("Summary: %0d check failures, %0d other errors", check_errs, other_errs);
   endtask

   // Build one packet, queue it for the driver and for the expected output
   task automatic queue_packet(input int k, input logic [7:0] dst_net,
                               input logic [7:0] dst_host);
      sid_t sid;
      int len;
      int idx;
      int port;
      logic [64:0] b;
      sid.src_net  = 8'(take_bits(8));
      // Source host names the input, used by the checker
      sid.src_host = 8'(k);
      sid.dst_net  = dst_net;
      sid.dst_host = dst_host;
      len = 2 + int'(take_bits(3) % 7);
      idx = route_index(sid, local_net);
      if (!tbl_known[k][idx]) begin
         other_errs++;
         $display("ERROR: stimulus uses CAM %0d entry %0d, which holds no known value", k, idx);
      end
      port = int'(route_port(k, sid, local_net));
      for (int i = 0; i < len; i++) begin
         if (i == 0) begin
            b = {seq, 16'(take_bits(16)), sid, 1'b0};
         end else begin
            // Payload tag: sequence, input, beat number
            b = {seq, 8'(k), 8'(i), take_bits(32), i == len - 1};
         end
         tx_q[k].push_back(b);
         exp_q[port*n_in + k].push_back(b);
      end
      exp_stat[k][port]++;
      total_beats += len;
      seq++;
   endtask

   // One setting-bus write, mirrored into the reference table
   task automatic write_entry(input int k, input logic bank, input logic [7:0] entry,
                              input logic [1:0] port);
      @(posedge clk);
      set_bus <= '{stb: 1'b1, addr: {7'(k), bank, entry}, data: {30'd0, port}};
      @(posedge clk);
      set_bus <= '0;
      tbl_mirror[k][{bank, entry}] = port;
      tbl_known[k][{bank, entry}]  = 1'b1;
   endtask

   // Until every queued beat has been sent and seen
   task automatic wait_drain();
      int busy;
      busy = 1;
      while (busy != 0) begin
         @(posedge clk);
         busy = 0;
         for (int k = 0; k < n_in; k++) begin
            busy += tx_q[k].size();
         end
         for (int q = 0; q < n_in*n_out; q++) begin
            busy += exp_q[q].size();
         end
      end
      repeat (10) @(posedge clk);
   endtask

   task automatic check_stats(input string phase);
      for (int k = 0; k < n_in; k++) begin
         for (int j = 0; j < n_out; j++) begin
            @(posedge clk);
            rb_in   <= `XBAR_IN_W'(k);
            rb_port <= `XBAR_PORT_W'(j);
            // Readback is combinational, stable by the falling edge
            @(negedge clk);
            check_value(65'(rb_data), 65'(exp_stat[k][j]),
                        $sformatf("%s count, input %0d output %0d", phase, k, j));
         end
      end
   endtask

   // Input driver, at most two packets in flight per input
   always @(posedge clk) begin
      logic [64:0] b;
      for (int k = 0; k < n_in; k++) begin
         if (reset || tx_q[k].size() == 0) begin
            in_stb[k] <= 1'b0;
         end else if (mid_tx[k] || (sent_pkts[k] - done_pkts[k] < 2)) begin
            b = tx_q[k].pop_front();
            in_beat[k] <= b;
            in_stb[k]  <= 1'b1;
            if (!mid_tx[k]) begin
               sent_pkts[k]++;
            end
            mid_tx[k] = !b[0];
         end else begin
            in_stb[k] <= 1'b0;
         end
      end
   end

   // Output checker, sampled away from the clock edge
   always @(negedge clk) begin
      axis_beat_t ob;
      logic [64:0] want;
      int q;
      for (int j = 0; j < n_out; j++) begin
         if (out_stb[j]) begin
            ob = out_beat[j];
            // Header names its source input
            if (!mid_rx[j]) begin
               cur_src[j] = int'(ob.data[23:16]);
            end
            if (cur_src[j] >= n_in) begin
               other_errs++;
               $display("ERROR: output %0d sent a beat from unknown input %0d", j, cur_src[j]);
            end else begin
               q = j*n_in + cur_src[j];
               if (exp_q[q].size() == 0) begin
                  other_errs++;
                  $display("ERROR: output %0d sent an unexpected beat from input %0d",
                           j, cur_src[j]);
               end else begin
                  want = exp_q[q].pop_front();
                  check_value(ob, want,
                              $sformatf("output %0d beat from input %0d", j, cur_src[j]));
                  if (ob.last) begin
                     done_pkts[cur_src[j]]++;
                  end
               end
            end
            mid_rx[j] = !ob.last;
         end
      end
   end

   // Watchdog, limit grows with the traffic queued so far
   always @(posedge clk) begin
      cycles++;
      if (cycles > 40 * total_beats + 2000) begin
         $display("ERROR: timeout after %0d cycles, packets are still outstanding", cycles);
         print_summary();
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      reset      = 1'b1;
      clear      = 1'b0;
      set_bus    = '0;
      local_addr = local_net;
      rb_in      = '0;
      rb_port    = '0;
      // Power-up table: host h to output h[7:4] for the first 64 hosts
      for (int k = 0; k < n_in; k++) begin
         for (int e = 0; e < `XBAR_CAM_SPAN; e++) begin
            tbl_known[k][e]  = (e >= 256) && (e < 256 + 16*n_out);
            tbl_mirror[k][e] = 2'((e - 256) / 16);
         end
      end
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      repeat (5) @(posedge clk);

      // Default host routing
      for (int i = 0; i < 8; i++) begin
         queue_packet(0, local_net, 8'(take_bits(6)));
         queue_packet(1, local_net, 8'(take_bits(6)));
      end
      wait_drain();

      // Remap hosts 0..15 in CAM 0 and hosts 16..31 in CAM 1 only
      for (int h = 0; h < 16; h++) begin
         write_entry(0, 1'b1, 8'(h), 2'd3);
         write_entry(1, 1'b1, 8'(h + 16), 2'd0);
      end
      for (int i = 0; i < 8; i++) begin
         queue_packet(0, local_net, 8'(take_bits(6)));
         queue_packet(1, local_net, 8'(take_bits(6)));
      end
      wait_drain();

      // Remote networks 0x10..0x17, host byte is ignored
      for (int n = 0; n < 8; n++) begin
         write_entry(0, 1'b0, 8'(16 + n), 2'(take_bits(2)));
         write_entry(1, 1'b0, 8'(16 + n), 2'(take_bits(2)));
      end
      for (int i = 0; i < 8; i++) begin
         queue_packet(0, 8'(16 + take_bits(3)), 8'(take_bits(8)));
         queue_packet(1, 8'(16 + take_bits(3)), 8'(take_bits(8)));
      end
      wait_drain();

      // Hosts 0x20..0x2F stay on output 2 in both CAMs
      for (int i = 0; i < 6; i++) begin
         queue_packet(0, local_net, 8'(32 + take_bits(4)));
         queue_packet(1, local_net, 8'(32 + take_bits(4)));
      end
      wait_drain();
      check_stats("traffic");

      // Clear counters and FIFOs, table contents survive
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      for (int k = 0; k < n_in; k++) begin
         for (int j = 0; j < n_out; j++) begin
            exp_stat[k][j] = 0;
         end
      end
      check_stats("cleared");
      for (int i = 0; i < 4; i++) begin
         queue_packet(0, local_net, 8'(take_bits(6)));
         queue_packet(1, 8'(16 + take_bits(3)), 8'(take_bits(8)));
         queue_packet(0, 8'(16 + take_bits(3)), 8'(take_bits(8)));
         queue_packet(1, local_net, 8'(take_bits(6)));
      end
      wait_drain();
      check_stats("post-clear traffic");

      print_summary();
      if (check_errs == 0 && other_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== rtl/fwd_cam.sv ====
//////////////////////////////////////////////////////////////////////
// Forwarding CAM: SID monitor, 512-entry output table,
// request/acknowledge FSM and per-output packet counters
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

module fwd_cam import xbar_pkg::*; #(
   parameter int BASE = 0
) (
   input  logic                         clk,
   input  logic                         i_reset,
   input  logic                         i_clear,
   // Head of the input FIFO, as seen by the arbiters
   input  axis_beat_t                   i_beat,
   input  logic                         i_valid,
   input  logic                         i_ready,
   input  logic                         i_pkt_present,
   input  logic [7:0]                   i_local_addr,
   input  set_bus_t                     i_set,
   input  logic [`XBAR_NUM_OUTPUTS-1:0] i_fwd_ack,
   input  logic [`XBAR_PORT_W-1:0]      i_rb_port,
   output logic [`XBAR_NUM_OUTPUTS-1:0] o_fwd_req,
   output logic [31:0]                  o_rb_count
);

   // Setting-bus page that selects this CAM
   localparam logic [6:0] base_page = 7'(BASE / `XBAR_CAM_SPAN);

   typedef enum logic {
      mon_sof,
      mon_eof
   } mon_state_t;

   typedef enum logic [1:0] {
      st_idle,
      st_forward,
      st_wait
   } req_state_t;

   mon_state_t mon_state;
   req_state_t req_state;

   sid_t       hdr_sid;
   sid_t       dst;
   logic       dst_valid;
   logic       dst_valid_reg;
   logic       local_dst;
   logic [8:0] read_addr;
   logic [8:0] read_addr_reg;
   logic [`XBAR_PORT_W-1:0] read_data;
   logic       tbl_wr;

   // Output index per entry, network bank low and host bank high
   logic [`XBAR_PORT_W-1:0] tbl [`XBAR_CAM_SPAN];
   logic [31:0] pkt_stat [`XBAR_NUM_OUTPUTS];

   assign hdr_sid = sid_t'(i_beat.data[31:0]);

   // SOF/EOF tracking on beats leaving the FIFO
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         mon_state <= mon_sof;
      end else begin
         case (mon_state)
            // Header pops, payload follows
            mon_sof: if (i_valid && i_ready) mon_state <= mon_eof;
            mon_eof: if (i_valid && i_ready && i_beat.last) mon_state <= mon_sof;
            default: mon_state <= mon_sof;
         endcase
      end
   end

   // Capture the header SID once the whole packet is stored
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         dst_valid     <= 1'b0;
         dst_valid_reg <= 1'b0;
      end else begin
         dst_valid     <= i_valid && i_pkt_present && (mon_state == mon_sof);
         dst_valid_reg <= dst_valid;
      end
   end

   // SID is payload, held steady until the header pops
   always_ff @(posedge clk) begin
      if (i_valid && i_pkt_present && (mon_state == mon_sof)) begin
         dst <= hdr_sid;
      end
   end

   // Our network byte picks the host bank, else the network bank
   assign local_dst = (dst.dst_net == i_local_addr) && dst_valid;
   assign read_addr = {local_dst, (local_dst ? dst.dst_host : dst.dst_net)};

   assign tbl_wr = i_set.stb && (i_set.addr[15:9] == base_page);

   // Host entry h defaults to output h[7:4]
   initial begin
      for (int p = 0; p < `XBAR_NUM_OUTPUTS; p++) begin
         for (int b = 0; b < 16; b++) begin
            tbl[256 + p*16 + b] = `XBAR_PORT_W'(p);
         end
      end
   end

   // Registered address, table read in the following cycle
   always_ff @(posedge clk) begin
      read_addr_reg <= read_addr;
      if (tbl_wr) begin
         tbl[i_set.addr[8:0]] <= i_set.data[`XBAR_PORT_W-1:0];
      end
   end

   assign read_data = tbl[read_addr_reg];

   // Request one output, drop it on ack, then wait for ack release
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         o_fwd_req <= '0;
         req_state <= st_idle;
      end else begin
         case (req_state)
            st_idle: begin
               if (dst_valid_reg) begin
                  o_fwd_req <= `XBAR_NUM_OUTPUTS'(1) << read_data;
                  req_state <= st_forward;
               end
            end
            st_forward: begin
               if ((o_fwd_req & i_fwd_ack) != '0) begin
                  o_fwd_req <= '0;
                  req_state <= st_wait;
               end
            end
            st_wait: begin
               // Ack stays up until the last beat is gone
               if (i_fwd_ack == '0) req_state <= st_idle;
            end
            default: req_state <= st_idle;
         endcase
      end
   end

   // One count per accepted request
   always_ff @(posedge clk) begin
      for (int m = 0; m < `XBAR_NUM_OUTPUTS; m++) begin
         if (i_reset || i_clear) begin
            pkt_stat[m] <= '0;
         end else if (o_fwd_req[m] && i_fwd_ack[m]) begin
            pkt_stat[m] <= pkt_stat[m] + 1'b1;
         end
      end
   end

   assign o_rb_count = pkt_stat[i_rb_port];

endmodule

// ==== rtl/out_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// Output port arbiter: round-robin grant and packet streaming
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

module out_arbiter import xbar_pkg::*; (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_clear,
   input  logic [`XBAR_NUM_INPUTS-1:0] i_req,
   input  axis_beat_t                  i_beat [`XBAR_NUM_INPUTS],
   input  logic [`XBAR_NUM_INPUTS-1:0] i_valid,
   output logic [`XBAR_NUM_INPUTS-1:0] o_ack,
   output logic [`XBAR_NUM_INPUTS-1:0] o_pop,
   output axis_beat_t                  o_out,
   output logic                        o_out_stb
);

   typedef logic [`XBAR_IN_W-1:0] in_idx_t;

   typedef enum logic [1:0] {
      st_idle,
      st_grant,
      st_stream
   } arb_state_t;

   arb_state_t state;
   in_idx_t    grant;
   in_idx_t    last_served;
   in_idx_t    next_sel;
   in_idx_t    cand;
   logic       found;
   logic       pop_now;

   // Search starts just past the input served last
   always_comb begin
      next_sel = last_served;
      found    = 1'b0;
      cand     = last_served;
      for (int i = 1; i <= `XBAR_NUM_INPUTS; i++) begin
         cand = in_idx_t'((int'(last_served) + i) % `XBAR_NUM_INPUTS);
         if (!found && i_req[cand]) begin
            next_sel = cand;
            found    = 1'b1;
         end
      end
   end

   // Whole packet is already stored, so valid holds until last
   assign pop_now = (state == st_stream) && i_valid[grant];

   always_comb begin
      o_pop        = '0;
      o_pop[grant] = pop_now;
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         state       <= st_idle;
         grant       <= '0;
         last_served <= in_idx_t'(`XBAR_NUM_INPUTS - 1);
         o_ack       <= '0;
         o_out_stb   <= 1'b0;
      end else begin
         o_out_stb <= pop_now;
         case (state)
            st_idle: begin
               if (found) begin
                  grant        <= next_sel;
                  o_ack        <= '0;
                  o_ack[next_sel] <= 1'b1;
                  state        <= st_grant;
               end
            end
            // One cycle of ack before the first pop
            st_grant: state <= st_stream;
            st_stream: begin
               if (pop_now && i_beat[grant].last) begin
                  o_ack       <= '0;
                  last_served <= grant;
                  state       <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Output beat register
   always_ff @(posedge clk) begin
      o_out <= i_beat[grant];
   end

endmodule

// ==== rtl/pkt_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Input packet FIFO with a count of complete packets held
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

module pkt_fifo import xbar_pkg::*; (
   input  logic       clk,
   input  logic       i_reset,
   input  logic       i_clear,
   input  logic       i_wr_stb,
   input  axis_beat_t i_wr_beat,
   input  logic       i_ready,
   output axis_beat_t o_beat,
   output logic       o_valid,
   output logic       o_pkt_present
);

   localparam int aw = $clog2(`XBAR_FIFO_DEPTH);
   localparam logic [aw:0] depth_c = (aw+1)'(`XBAR_FIFO_DEPTH);

   // Beat storage
   axis_beat_t mem [`XBAR_FIFO_DEPTH];

   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   // Beats stored, and complete packets stored
   logic [aw:0]   beat_count;
   logic [aw:0]   pkt_count;
   logic          full;
   logic          do_wr;
   logic          do_rd;
   logic          pkt_in;
   logic          pkt_out;

   assign full = (beat_count == depth_c);
   // Overflowing beats are simply lost
   assign do_wr = i_wr_stb && !full;
   assign do_rd = i_ready && o_valid;

   // A packet is complete once its last beat is in
   assign pkt_in  = do_wr && i_wr_beat.last;
   assign pkt_out = do_rd && o_beat.last;

   // Head of queue, visible the cycle after the write
   assign o_beat        = mem[rd_ptr];
   assign o_valid       = (beat_count != '0);
   assign o_pkt_present = (pkt_count != '0);

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= i_wr_beat;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         beat_count <= '0;
         pkt_count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         case ({do_wr, do_rd})
            2'b10:   beat_count <= beat_count + 1'b1;
            2'b01:   beat_count <= beat_count - 1'b1;
            default: beat_count <= beat_count;
         endcase
         case ({pkt_in, pkt_out})
            2'b10:   pkt_count <= pkt_count + 1'b1;
            2'b01:   pkt_count <= pkt_count - 1'b1;
            default: pkt_count <= pkt_count;
         endcase
      end
   end

endmodule

// ==== rtl/xbar_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Crossbar sizing and setting-bus layout constants
//////////////////////////////////////////////////////////////////////
`ifndef XBAR_CONSTS_SVH
`define XBAR_CONSTS_SVH

// Port counts and the index widths that go with them
`define XBAR_NUM_INPUTS  2
`define XBAR_NUM_OUTPUTS 4
`define XBAR_PORT_W      2
`define XBAR_IN_W        1

// Stream beat payload width
`define XBAR_DATA_W      64

// Beats held per input FIFO
`define XBAR_FIFO_DEPTH  32

// Setting addresses owned by each CAM (256 network + 256 host entries)
`define XBAR_CAM_SPAN    512

`endif

// ==== rtl/xbar_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared crossbar types: stream ID, stream beat, setting-bus write
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

package xbar_pkg;

   // Stream ID in the low word of a header beat
   // Source half in the upper 16 bits, destination half in the lower 16
   typedef struct packed {
      logic [7:0] src_net;
      logic [7:0] src_host;
      logic [7:0] dst_net;
      logic [7:0] dst_host;
   } sid_t;

   // One stream beat
   typedef struct packed {
      logic [`XBAR_DATA_W-1:0] data;
      // End of packet marker
      logic                    last;
   } axis_beat_t;

   // One setting-bus write, valid for the single cycle of stb
   typedef struct packed {
      logic        stb;
      // Upper 7 bits pick the CAM, bit 8 the bank, bits 7:0 the entry
      logic [15:0] addr;
      logic [31:0] data;
   } set_bus_t;

endpackage

// ==== rtl/xbar_top.sv ====
//////////////////////////////////////////////////////////////////////
// Packet crossbar top: input FIFOs and CAMs, output arbiters,
// request/ack transpose and statistics readback
//////////////////////////////////////////////////////////////////////
`include "xbar_consts.svh"

module xbar_top import xbar_pkg::*; (
   input  logic                         clk,
   input  logic                         i_reset,
   input  logic                         i_clear,
   input  axis_beat_t                   i_in [`XBAR_NUM_INPUTS],
   input  logic [`XBAR_NUM_INPUTS-1:0]  i_in_stb,
   input  set_bus_t                     i_set,
   input  logic [7:0]                   i_local_addr,
   input  logic [`XBAR_IN_W-1:0]        i_rb_in,
   input  logic [`XBAR_PORT_W-1:0]      i_rb_port,
   output axis_beat_t                   o_out [`XBAR_NUM_OUTPUTS],
   output logic [`XBAR_NUM_OUTPUTS-1:0] o_out_stb,
   output logic [31:0]                  o_rb_data
);

   // FIFO heads
   axis_beat_t fifo_beat [`XBAR_NUM_INPUTS];
   logic [`XBAR_NUM_INPUTS-1:0] fifo_valid;
   logic [`XBAR_NUM_INPUTS-1:0] fifo_present;
   logic [`XBAR_NUM_INPUTS-1:0] fifo_pop;

   // Per input, indexed by output
   logic [`XBAR_NUM_OUTPUTS-1:0] cam_req [`XBAR_NUM_INPUTS];
   logic [`XBAR_NUM_OUTPUTS-1:0] cam_ack [`XBAR_NUM_INPUTS];
   logic [31:0] cam_count [`XBAR_NUM_INPUTS];

   // Per output, indexed by input
   logic [`XBAR_NUM_INPUTS-1:0] arb_req [`XBAR_NUM_OUTPUTS];
   logic [`XBAR_NUM_INPUTS-1:0] arb_ack [`XBAR_NUM_OUTPUTS];
   logic [`XBAR_NUM_INPUTS-1:0] arb_pop [`XBAR_NUM_OUTPUTS];

   for (genvar k = 0; k < `XBAR_NUM_INPUTS; k++) begin : g_in
      pkt_fifo u_fifo (
         .clk           (clk),
         .i_reset       (i_reset),
         .i_clear       (i_clear),
         .i_wr_stb      (i_in_stb[k]),
         .i_wr_beat     (i_in[k]),
         .i_ready       (fifo_pop[k]),
         .o_beat        (fifo_beat[k]),
         .o_valid       (fifo_valid[k]),
         .o_pkt_present (fifo_present[k])
      );

      // Each CAM owns its own 512-address page
      fwd_cam #(.BASE(k * `XBAR_CAM_SPAN)) u_cam (
         .clk           (clk),
         .i_reset       (i_reset),
         .i_clear       (i_clear),
         .i_beat        (fifo_beat[k]),
         .i_valid       (fifo_valid[k]),
         .i_ready       (fifo_pop[k]),
         .i_pkt_present (fifo_present[k]),
         .i_local_addr  (i_local_addr),
         .i_set         (i_set),
         .i_fwd_ack     (cam_ack[k]),
         .i_rb_port     (i_rb_port),
         .o_fwd_req     (cam_req[k]),
         .o_rb_count    (cam_count[k])
      );
   end

   for (genvar j = 0; j < `XBAR_NUM_OUTPUTS; j++) begin : g_out
      out_arbiter u_arb (
         .clk       (clk),
         .i_reset   (i_reset),
         .i_clear   (i_clear),
         .i_req     (arb_req[j]),
         .i_beat    (fifo_beat),
         .i_valid   (fifo_valid),
         .o_ack     (arb_ack[j]),
         .o_pop     (arb_pop[j]),
         .o_out     (o_out[j]),
         .o_out_stb (o_out_stb[j])
      );
   end

   // Swap input/output indexing between CAMs and arbiters
   // Only one arbiter at a time pops a given input
   always_comb begin
      for (int k = 0; k < `XBAR_NUM_INPUTS; k++) begin
         fifo_pop[k] = 1'b0;
         for (int j = 0; j < `XBAR_NUM_OUTPUTS; j++) begin
            arb_req[j][k] = cam_req[k][j];
            cam_ack[k][j] = arb_ack[j][k];
            fifo_pop[k]   = fifo_pop[k] | arb_pop[j][k];
         end
      end
   end

   // Statistics readback, port chosen inside each CAM
   assign o_rb_data = cam_count[i_rb_in];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary -j 0 --timescale 1ns/100ps --top-module xbar_tb \
   -f build.f -o xbar_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/xbar_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
   echo "Simulation passed"
   exit 0
fi

echo "Simulation failed, see sim.log"
exit 1
